//--- sim.f
+incdir+testbench
design/soc_pkg.sv
design/apb_if.sv
design/por.sv
design/apb_decoder.sv
design/ram_slave.sv
design/gpio_slave.sv
design/hex_slave.sv
design/exti_slave.sv
design/periph_top.sv
testbench/tb_periph_top.sv

//--- Makefile
TOP = tb_periph_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- testbench/tb_tasks.svh
task automatic report_mismatch(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
    errors++;
    $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
endtask

function automatic logic [ADDR_W-1:0] win_addr(input logic [ADDR_W-1:0] base,
                                               input logic [WIN_AW-1:0] offset);
    return base + ADDR_W'(offset);
endfunction

// Lit segments gfedcba for 0 to F; the board display is active low.
function automatic logic [6:0] seg_pattern(input logic [3:0] v);
    logic [6:0] lit [16];
    lit = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
            7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
    return ~lit[v];
endfunction

// Access phase is sampled on the falling edge, where pready has settled.
task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                            output logic err, output int waits);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waits   = 0;
    @(negedge clk);
    while (!pready) begin
        waits++;
        @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);  // Completion edge.
    #1;
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                         output logic err, output int waits);
    logic [DATA_W-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err, waits);
endtask

task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                        output logic err, output int waits);
    apb_transfer(1'b0, addr, '0, data, err, waits);
endtask

task automatic test_ram();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rdata;
    logic              err;
    int                waits;
    tests++;
    for (int i = 0; i < 16; i++) begin
        addr         = ADDR_W'(i * 17 * 4);  // Word indices 0, 17, ... 255.
        ram_model[i] = $random(seed);
        apb_write(addr, ram_model[i], err, waits);
        if (waits != 1)
            report_mismatch($sformatf("RAM write wait cycles at %h", addr), 64'(waits), 64'd1);
    end
    for (int i = 0; i < 16; i++) begin
        addr = ADDR_W'(i * 17 * 4);
        apb_read(addr, rdata, err, waits);
        if (rdata !== ram_model[i])
            report_mismatch($sformatf("RAM read at %h", addr), 64'(rdata), 64'(ram_model[i]));
        if (waits != 1)
            report_mismatch($sformatf("RAM read wait cycles at %h", addr), 64'(waits), 64'd1);
        if (err !== 1'b0)
            report_mismatch($sformatf("RAM read pslverr at %h", addr), 64'(err), 64'd0);
    end
endtask

task automatic test_decoder();
    logic [ADDR_W-1:0] bad_addr [2];
    logic [DATA_W-1:0] rdata;
    logic              err;
    int                waits;
    tests++;
    bad_addr[0] = 12'h700;
    bad_addr[1] = 12'hffc;
    for (int i = 0; i < 2; i++) begin
        apb_write(bad_addr[i], $random(seed), err, waits);
        if (err !== 1'b1)
            report_mismatch($sformatf("pslverr on write to %h", bad_addr[i]), 64'(err), 64'd1);
        if (waits != 0)
            report_mismatch("unmapped write wait cycles", 64'(waits), 64'd0);
        apb_read(bad_addr[i], rdata, err, waits);
        if (err !== 1'b1)
            report_mismatch($sformatf("pslverr on read of %h", bad_addr[i]), 64'(err), 64'd1);
        if (rdata !== '0)
            report_mismatch($sformatf("prdata of %h", bad_addr[i]), 64'(rdata), 64'd0);
    end
    apb_read(ADDR_W'(5 * 17 * 4), rdata, err, waits);
    if (rdata !== ram_model[5])
        report_mismatch("RAM word after unmapped accesses", 64'(rdata), 64'(ram_model[5]));
endtask

task automatic test_gpio();
    logic [DATA_W-1:0] rdata;
    logic              err;
    int                waits;
    tests++;
    apb_write(win_addr(GPIO_BASE, REG_GPIO_DIR), 32'h3a5, err, waits);
    apb_write(win_addr(GPIO_BASE, REG_GPIO_OUT), 32'h2c3, err, waits);
    if (waits != 0)
        report_mismatch("GPIO write wait cycles", 64'(waits), 64'd0);
    if (gpio_oe !== 10'h3a5)
        report_mismatch("gpio_oe", 64'(gpio_oe), 64'h3a5);
    if (gpio_out !== 10'h2c3)
        report_mismatch("gpio_out", 64'(gpio_out), 64'h2c3);
    apb_read(win_addr(GPIO_BASE, REG_GPIO_DIR), rdata, err, waits);
    if (rdata !== 32'h3a5)
        report_mismatch("GPIO direction readback", 64'(rdata), 64'h3a5);

    @(posedge clk);
    #1;
    gpio_in = 10'h15a;
    repeat (3) @(posedge clk);  // Two synchroniser stages plus margin.
    apb_read(win_addr(GPIO_BASE, REG_GPIO_IN), rdata, err, waits);
    if (rdata !== 32'h15a)
        report_mismatch("GPIO input register", 64'(rdata), 64'h15a);
endtask

task automatic test_hex();
    logic [4*HEX_NUM-1:0] val;
    logic [HEX_NUM-1:0]   blank;
    logic [7*HEX_NUM-1:0] exp;
    logic                 err;
    int                   waits;
    tests++;
    if (hex_seg !== '1)
        report_mismatch("hex_seg after reset", 64'(hex_seg), 64'h3ff_ffff_ffff);
    val   = 24'h9c5fa1;
    blank = 6'b001010;
    apb_write(win_addr(HEX_BASE, REG_HEX_VAL), {8'h00, val}, err, waits);
    apb_write(win_addr(HEX_BASE, REG_HEX_BLANK), {26'h0, blank}, err, waits);
    for (int i = 0; i < HEX_NUM; i++)
        exp[7*i +: 7] = blank[i] ? 7'h7f : seg_pattern(val[4*i +: 4]);
    if (hex_seg !== exp)
        report_mismatch("hex_seg with digits and blank mask", 64'(hex_seg), 64'(exp));
endtask

task automatic test_exti();
    logic [DATA_W-1:0] rdata;
    logic              err;
    int                waits;
    tests++;
    @(posedge clk);
    #1;
    exti_pins = 12'h008;
    repeat (4) @(posedge clk);
    #1;
    exti_pins = 12'h000;
    @(negedge clk);
    if (irq !== 1'b0)
        report_mismatch("irq with enable zero", 64'(irq), 64'd0);
    apb_read(win_addr(EXTI_BASE, REG_EXTI_PEND), rdata, err, waits);
    if (rdata !== 32'h008)
        report_mismatch("pending with enable zero", 64'(rdata), 64'h008);

    apb_write(win_addr(EXTI_BASE, REG_EXTI_EN), 32'h008, err, waits);
    if (irq !== 1'b1)
        report_mismatch("irq after enable", 64'(irq), 64'd1);
    apb_write(win_addr(EXTI_BASE, REG_EXTI_PEND), 32'h008, err, waits);
    if (irq !== 1'b0)
        report_mismatch("irq after clear", 64'(irq), 64'd0);
    apb_read(win_addr(EXTI_BASE, REG_EXTI_PEND), rdata, err, waits);
    if (rdata !== '0)
        report_mismatch("pending after clear", 64'(rdata), 64'd0);

    apb_write(win_addr(EXTI_BASE, REG_EXTI_EN), 32'h428, err, waits);
    @(posedge clk);
    #1;
    exti_pins = 12'h420;
    repeat (2) @(posedge clk);
    #1;
    exti_pins = 12'h000;
    repeat (4) @(posedge clk);
    apb_read(win_addr(EXTI_BASE, REG_EXTI_PEND), rdata, err, waits);
    if (rdata !== 32'h420)
        report_mismatch("pending mask after two pulses", 64'(rdata), 64'h420);
    if (irq !== 1'b1)
        report_mismatch("irq after two pulses", 64'(irq), 64'd1);
endtask

//--- testbench/tb_periph_top.sv
`timescale 1ns/1ps

module tb_periph_top;
    import soc_pkg::*;

    // The five tests finish in well under a thousand cycles.
    localparam int TIMEOUT_CYCLES = 5000;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [ADDR_W-1:0]     paddr;
    logic [DATA_W-1:0]     pwdata;
    logic [DATA_W-1:0]     prdata;
    logic                  pready;
    logic                  pslverr;
    logic [GPIO_NUM-1:0]   gpio_in;
    logic [GPIO_NUM-1:0]   gpio_out;
    logic [GPIO_NUM-1:0]   gpio_oe;
    logic [EXTI_NUM-1:0]   exti_pins;
    logic                  irq;
    logic [7*HEX_NUM-1:0]  hex_seg;

    logic [DATA_W-1:0]     ram_model [16];  // Words written by the RAM test.
    int                    errors;
    int                    tests;
    int                    cycles;
    int                    seed;

    periph_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .exti_pins(exti_pins),
        .irq      (irq),
        .hex_seg  (hex_seg)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence did not end within %0d cycles.", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    `include "tb_tasks.svh"

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        gpio_in   = '0;
        exti_pins = '0;
        errors    = 0;
        tests     = 0;
        cycles    = 0;
        seed      = 32'h4a3f;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (POR_CYCLES + 2) @(posedge clk);  // Let the stretched reset go away.

        test_ram();
        test_decoder();
        test_gpio();
        test_hex();
        test_exti();

        $display("Ran %0d tests, %0d errors.", tests, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end
endmodule

//--- design/periph_top.sv
`timescale 1ns/1ps

module periph_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [soc_pkg::ADDR_W-1:0]    paddr,
    input  logic [soc_pkg::DATA_W-1:0]    pwdata,
    output logic [soc_pkg::DATA_W-1:0]    prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic [soc_pkg::GPIO_NUM-1:0]  gpio_in,
    output logic [soc_pkg::GPIO_NUM-1:0]  gpio_out,
    output logic [soc_pkg::GPIO_NUM-1:0]  gpio_oe,
    input  logic [soc_pkg::EXTI_NUM-1:0]  exti_pins,
    output logic                          irq,
    output logic [7*soc_pkg::HEX_NUM-1:0] hex_seg
);
    logic sys_rst_n;

    apb_if ext_bus ();
    apb_if ram_bus ();
    apb_if gpio_bus ();
    apb_if hex_bus ();
    apb_if exti_bus ();

    assign ext_bus.psel    = psel;
    assign ext_bus.penable = penable;
    assign ext_bus.pwrite  = pwrite;
    assign ext_bus.paddr   = paddr;
    assign ext_bus.pwdata  = pwdata;
    assign prdata          = ext_bus.prdata;
    assign pready          = ext_bus.pready;
    assign pslverr         = ext_bus.pslverr;

    por u_por (.clk(clk), .rst_n(rst_n), .sys_rst_n(sys_rst_n));

    apb_decoder u_decoder (
        .clk  (clk),
        .rst_n(sys_rst_n),
        .mgr  (ext_bus),
        .ram  (ram_bus),
        .gpio (gpio_bus),
        .hex  (hex_bus),
        .exti (exti_bus)
    );

    ram_slave u_ram (.clk(clk), .rst_n(sys_rst_n), .bus(ram_bus));

    gpio_slave u_gpio (
        .clk     (clk),
        .rst_n   (sys_rst_n),
        .bus     (gpio_bus),
        .pins_in (gpio_in),
        .pins_out(gpio_out),
        .pins_oe (gpio_oe)
    );

    hex_slave u_hex (.clk(clk), .rst_n(sys_rst_n), .bus(hex_bus), .seg(hex_seg));

    exti_slave u_exti (
        .clk  (clk),
        .rst_n(sys_rst_n),
        .bus  (exti_bus),
        .pins (exti_pins),
        .irq  (irq)
    );
endmodule

//--- design/exti_slave.sv
`timescale 1ns/1ps

module exti_slave (
    input  logic                         clk,
    input  logic                         rst_n,
    apb_if.completer                     bus,
    input  logic [soc_pkg::EXTI_NUM-1:0] pins,
    output logic                         irq
);
    import soc_pkg::*;

    logic [EXTI_NUM-1:0] sync1_q;
    logic [EXTI_NUM-1:0] sync2_q;
    logic [EXTI_NUM-1:0] edge_q;
    logic [EXTI_NUM-1:0] en_q;
    logic [EXTI_NUM-1:0] pend_q;
    logic [EXTI_NUM-1:0] rise;
    logic [EXTI_NUM-1:0] clr;
    logic                wr_en;

    assign wr_en = bus.psel && bus.penable && bus.pwrite;
    assign rise  = sync2_q & ~edge_q;
    assign clr   = (wr_en && bus.paddr[WIN_AW-1:0] == REG_EXTI_PEND) ?
                   bus.pwdata[EXTI_NUM-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
            edge_q  <= '0;
            en_q    <= '0;
            pend_q  <= '0;
        end else begin
            sync1_q <= pins;
            sync2_q <= sync1_q;
            edge_q  <= sync2_q;
            pend_q  <= (pend_q & ~clr) | rise;  // A fresh edge beats the clear.
            if (wr_en && bus.paddr[WIN_AW-1:0] == REG_EXTI_EN)
                en_q <= bus.pwdata[EXTI_NUM-1:0];
        end
    end

    always_comb begin
        case (bus.paddr[WIN_AW-1:0])
            REG_EXTI_EN:   bus.prdata = DATA_W'(en_q);
            REG_EXTI_PEND: bus.prdata = DATA_W'(pend_q);
            default:       bus.prdata = '0;
        endcase
    end

    assign irq         = |(pend_q & en_q);
    assign bus.pready  = bus.psel && bus.penable;
    assign bus.pslverr = 1'b0;
endmodule

//--- design/hex_slave.sv
`timescale 1ns/1ps

module hex_slave (
    input  logic                          clk,
    input  logic                          rst_n,
    apb_if.completer                      bus,
    output logic [7*soc_pkg::HEX_NUM-1:0] seg
);
    import soc_pkg::*;

    logic [4*HEX_NUM-1:0] val_q;
    logic [HEX_NUM-1:0]   blank_q;
    logic                 wr_en;

    assign wr_en = bus.psel && bus.penable && bus.pwrite;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            val_q   <= '0;
            blank_q <= '1;  // Display starts dark.
        end else if (wr_en) begin
            if (bus.paddr[WIN_AW-1:0] == REG_HEX_VAL)
                val_q <= bus.pwdata[4*HEX_NUM-1:0];
            if (bus.paddr[WIN_AW-1:0] == REG_HEX_BLANK)
                blank_q <= bus.pwdata[HEX_NUM-1:0];
        end
    end

    always_comb begin
        case (bus.paddr[WIN_AW-1:0])
            REG_HEX_VAL:   bus.prdata = DATA_W'(val_q);
            REG_HEX_BLANK: bus.prdata = DATA_W'(blank_q);
            default:       bus.prdata = '0;
        endcase
    end

    for (genvar i = 0; i < HEX_NUM; i++) begin : g_digit
        assign seg[7*i +: 7] = blank_q[i] ? 7'h7f : seg7_encode(val_q[4*i +: 4]);
    end

    assign bus.pready  = bus.psel && bus.penable;
    assign bus.pslverr = 1'b0;
endmodule

//--- design/gpio_slave.sv
`timescale 1ns/1ps

module gpio_slave (
    input  logic                         clk,
    input  logic                         rst_n,
    apb_if.completer                     bus,
    input  logic [soc_pkg::GPIO_NUM-1:0] pins_in,
    output logic [soc_pkg::GPIO_NUM-1:0] pins_out,
    output logic [soc_pkg::GPIO_NUM-1:0] pins_oe
);
    import soc_pkg::*;

    logic [GPIO_NUM-1:0] out_q;
    logic [GPIO_NUM-1:0] dir_q;
    logic [GPIO_NUM-1:0] sync1_q;
    logic [GPIO_NUM-1:0] sync2_q;
    logic                wr_en;

    assign wr_en = bus.psel && bus.penable && bus.pwrite;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q   <= '0;
            dir_q   <= '0;  // All pins start as inputs.
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= pins_in;
            sync2_q <= sync1_q;
            if (wr_en && bus.paddr[WIN_AW-1:0] == REG_GPIO_OUT)
                out_q <= bus.pwdata[GPIO_NUM-1:0];
            if (wr_en && bus.paddr[WIN_AW-1:0] == REG_GPIO_DIR)
                dir_q <= bus.pwdata[GPIO_NUM-1:0];
        end
    end

    always_comb begin
        case (bus.paddr[WIN_AW-1:0])
            REG_GPIO_OUT: bus.prdata = DATA_W'(out_q);
            REG_GPIO_DIR: bus.prdata = DATA_W'(dir_q);
            REG_GPIO_IN:  bus.prdata = DATA_W'(sync2_q);
            default:      bus.prdata = '0;
        endcase
    end

    assign bus.pready  = bus.psel && bus.penable;
    assign bus.pslverr = 1'b0;
    assign pins_out    = out_q;
    assign pins_oe     = dir_q;
endmodule

//--- design/ram_slave.sv
`timescale 1ns/1ps

module ram_slave (
    input logic      clk,
    input logic      rst_n,
    apb_if.completer bus
);
    import soc_pkg::*;

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic [RAM_AW-1:0] word_idx;
    logic              wait_q;

    assign word_idx = bus.paddr[RAM_AW+1:2];

    // Set during the first access cycle, so pready comes one cycle late.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wait_q <= 1'b0;
        else
            wait_q <= bus.psel && bus.penable && !wait_q;
    end

    always_ff @(posedge clk) begin
        if (bus.psel)
            rdata_q <= mem[word_idx];  // Registered read, like a block RAM.
        if (bus.psel && bus.penable && wait_q && bus.pwrite)
            mem[word_idx] <= bus.pwdata;
    end

    assign bus.pready  = bus.psel && bus.penable && wait_q;
    assign bus.prdata  = rdata_q;
    assign bus.pslverr = 1'b0;
endmodule

//--- design/apb_decoder.sv
`timescale 1ns/1ps

module apb_decoder (
    input logic      clk,
    input logic      rst_n,
    apb_if.completer mgr,
    apb_if.manager   ram,
    apb_if.manager   gpio,
    apb_if.manager   hex,
    apb_if.manager   exti
);
    import soc_pkg::*;

    slave_e target;

    always_comb begin
        if (mgr.paddr < ADDR_W'(RAM_WORDS * 4)) begin
            target = slv_ram;
        end else begin
            case (mgr.paddr[ADDR_W-1:WIN_AW])
                GPIO_BASE[ADDR_W-1:WIN_AW]: target = slv_gpio;
                HEX_BASE[ADDR_W-1:WIN_AW]:  target = slv_hex;
                EXTI_BASE[ADDR_W-1:WIN_AW]: target = slv_exti;
                default:                    target = slv_none;
            endcase
        end
    end

    assign ram.psel     = mgr.psel && (target == slv_ram);
    assign ram.penable  = mgr.penable;
    assign ram.pwrite   = mgr.pwrite;
    assign ram.paddr    = ADDR_W'(mgr.paddr[RAM_AW+1:0]);
    assign ram.pwdata   = mgr.pwdata;
    assign gpio.psel    = mgr.psel && (target == slv_gpio);
    assign gpio.penable = mgr.penable;
    assign gpio.pwrite  = mgr.pwrite;
    assign gpio.paddr   = ADDR_W'(mgr.paddr[WIN_AW-1:0]); // Offset within the window.
    assign gpio.pwdata  = mgr.pwdata;
    assign hex.psel     = mgr.psel && (target == slv_hex);
    assign hex.penable  = mgr.penable;
    assign hex.pwrite   = mgr.pwrite;
    assign hex.paddr    = ADDR_W'(mgr.paddr[WIN_AW-1:0]);
    assign hex.pwdata   = mgr.pwdata;
    assign exti.psel    = mgr.psel && (target == slv_exti);
    assign exti.penable = mgr.penable;
    assign exti.pwrite  = mgr.pwrite;
    assign exti.paddr   = ADDR_W'(mgr.paddr[WIN_AW-1:0]);
    assign exti.pwdata  = mgr.pwdata;

    always_comb begin
        case (target)
            slv_ram:  {mgr.prdata, mgr.pready, mgr.pslverr} = {ram.prdata, ram.pready, ram.pslverr};
            slv_gpio: {mgr.prdata, mgr.pready, mgr.pslverr} = {gpio.prdata, gpio.pready, gpio.pslverr};
            slv_hex:  {mgr.prdata, mgr.pready, mgr.pslverr} = {hex.prdata, hex.pready, hex.pslverr};
            slv_exti: {mgr.prdata, mgr.pready, mgr.pslverr} = {exti.prdata, exti.pready, exti.pslverr};
            default: begin
                // Unmapped addresses end in the first access cycle with an error.
                mgr.prdata  = '0;
                mgr.pready  = mgr.psel && mgr.penable;
                mgr.pslverr = mgr.psel && mgr.penable;
            end
        endcase
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mgr.psel && mgr.penable && !mgr.pready |=> $stable(mgr.paddr));
endmodule

//--- design/por.sv
`timescale 1ns/1ps

module por (
    input  logic clk,
    input  logic rst_n,
    output logic sys_rst_n
);
    import soc_pkg::*;

    logic [POR_CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            sys_rst_n <= 1'b0;
        end else if (!sys_rst_n) begin
            cnt <= cnt + 1'b1;
            // Release on the POR_CYCLES-th edge after the board reset goes away.
            if (cnt == POR_CNT_W'(POR_CYCLES - 1))
                sys_rst_n <= 1'b1;
        end
    end

    // The system reset may only be released after the board reset has been high for a while.
    a_no_early_release: assert property (@(posedge clk)
        $rose(sys_rst_n) |-> rst_n && $past(rst_n, POR_CYCLES - 1));
endmodule

//--- design/apb_if.sv
`timescale 1ns/1ps

interface apb_if #(
    parameter int ADDR_W = soc_pkg::ADDR_W,
    parameter int DATA_W = soc_pkg::DATA_W
);
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    modport manager (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport completer (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );
endinterface

//--- design/soc_pkg.sv
package soc_pkg;
    localparam int ADDR_W     = 12;
    localparam int DATA_W     = 32;
    localparam int POR_CYCLES = 16;
    localparam int POR_CNT_W  = $clog2(POR_CYCLES);
    localparam int RAM_WORDS  = 256;
    localparam int RAM_AW     = $clog2(RAM_WORDS);
    localparam int WIN_AW     = 8;  // Each peripheral owns a 256-byte window.

    localparam logic [ADDR_W-1:0] GPIO_BASE = 12'h400;
    localparam logic [ADDR_W-1:0] HEX_BASE  = 12'h500;
    localparam logic [ADDR_W-1:0] EXTI_BASE = 12'h600;

    localparam int GPIO_NUM = 10;
    localparam int EXTI_NUM = 12;
    localparam int HEX_NUM  = 6;

    localparam logic [WIN_AW-1:0] REG_GPIO_OUT  = 8'h00;
    localparam logic [WIN_AW-1:0] REG_GPIO_DIR  = 8'h04;
    localparam logic [WIN_AW-1:0] REG_GPIO_IN   = 8'h08;
    localparam logic [WIN_AW-1:0] REG_HEX_VAL   = 8'h00;
    localparam logic [WIN_AW-1:0] REG_HEX_BLANK = 8'h04;
    localparam logic [WIN_AW-1:0] REG_EXTI_EN   = 8'h00;
    localparam logic [WIN_AW-1:0] REG_EXTI_PEND = 8'h04;

    typedef enum logic [2:0] {
        slv_ram,
        slv_gpio,
        slv_hex,
        slv_exti,
        slv_none
    } slave_e;

    // Segments are active low, ordered gfedcba.
    function automatic logic [6:0] seg7_encode(input logic [3:0] val);
        logic [6:0] seg;
        case (val)
            4'h0: seg = 7'h40;
            4'h1: seg = 7'h79;
            4'h2: seg = 7'h24;
            4'h3: seg = 7'h30;
            4'h4: seg = 7'h19;
            4'h5: seg = 7'h12;
            4'h6: seg = 7'h02;
            4'h7: seg = 7'h78;
            4'h8: seg = 7'h00;
            4'h9: seg = 7'h10;
            4'ha: seg = 7'h08;
            4'hb: seg = 7'h03;
            4'hc: seg = 7'h46;
            4'hd: seg = 7'h21;
            4'he: seg = 7'h06;
            default: seg = 7'h0e;
        endcase
        return seg;
    endfunction
endpackage
